/* Makefile */
TOP = tb_spmd_load_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then \
	  echo "simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* image.hex */
// one 32-bit image word per column and four words to a line in rom address order
// words 0 to 15 hold the dmem image and words 16 to 31 the dram image
A0000000 A1020304 A2040608 A306090C
A4080C10 A50A0F14 A60C1218 A70E151C
A8101820 A9121B24 AA141E28 AB16212C
AC182430 AD1A2734 AE1C2A38 AF1E2D3C
B0203040 B1223344 B2243648 B326394C
B4283C50 B52A3F54 B62C4258 B72E455C
B8304860 B9324B64 BA344E68 BB36516C
BC385470 BD3A5774 BE3C5A78 BF3E5D7C

/* load_image_rom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module load_image_rom
  import loader_pkg::*;
(
  input  logic        clk_i,
  input  rom_addr_t   addr_i,
  output image_word_t data_o
);

  localparam int words_lp = `DMEM_WORDS_P + `DRAM_WORDS_P;

  image_word_t mem_r [words_lp];

  // dmem words first, then dram words
  initial begin
    $readmemh("image.hex", mem_r);
  end

  // one cycle read latency
  always_ff @(posedge clk_i) begin
    data_o <= mem_r[addr_i];
  end

endmodule

`default_nettype wire

/* loader_params.svh */
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

//////////////////////////////
// array geometry

`define NUM_ROWS_P           2  // tile rows
`define NUM_COLS_P           2  // tile columns

//////////////////////////////
// memory sizes, in words

`define ICACHE_ENTRIES_P     4  // tag entries cleared per tile
`define DMEM_WORDS_P         16
`define DRAM_WORDS_P         16

//////////////////////////////
// widths

`define DATA_WIDTH_P         32
`define ADDR_WIDTH_P         16 // word address carried in a packet
`define EPA_ADDR_WIDTH_P     12 // top bit selects the config space
`define DRAM_CH_ADDR_WIDTH_P 14

//////////////////////////////
// flow control

`define LOADER_CREDITS_P     4  // also the output queue depth
`define LINK_CREDITS_P       2  // initial credits on the external link

`endif

/* loader_pkg.sv */
`default_nettype none

`include "loader_params.svh"

package loader_pkg;

  // order of the load sequence
  typedef enum logic [2:0] {
    e_idle     = 3'd0,
    e_icache   = 3'd1, // clear icache tags
    e_dmem     = 3'd2, // copy dmem image to every tile
    e_dram     = 3'd3, // copy dram image to the controllers
    e_unfreeze = 3'd4, // release the tiles
    e_done     = 3'd5
  } load_phase_e;

  // dmem image sits first in the rom, dram image right after it
  typedef logic [$clog2(`DMEM_WORDS_P+`DRAM_WORDS_P)-1:0] rom_addr_t;

  typedef logic [`DATA_WIDTH_P-1:0] image_word_t;

endpackage

`default_nettype wire

/* noc_pkg.sv */
`default_nettype none

`include "loader_params.svh"

package noc_pkg;

  // y needs one extra row below the array for the dram controllers
  typedef logic [1:0] x_cord_t;
  typedef logic [1:0] y_cord_t;

  typedef enum logic [1:0] {
    e_remote_load  = 2'd0,
    e_remote_store = 2'd1
  } packet_op_e;

  // tile-side endpoint address
  typedef struct packed {
    logic [`ADDR_WIDTH_P-`EPA_ADDR_WIDTH_P-1:0] reserved;
    logic                                       config_bit; // csr space
    logic [`EPA_ADDR_WIDTH_P-2:0]               offset;     // local word offset
  } epa_addr_s;

  // dram-side address, column of the controller sits on top
  typedef struct packed {
    x_cord_t                           x_cord;
    logic [`DRAM_CH_ADDR_WIDTH_P-1:0]  ch_addr;
  } dram_addr_s;

  typedef union packed {
    epa_addr_s  epa;
    dram_addr_s dram;
  } packet_addr_u;

  typedef struct packed {
    logic [`DATA_WIDTH_P-1:0] data;
    packet_addr_u             addr;
    packet_op_e               op;
    logic [3:0]               mask;        // byte enables
    x_cord_t                  x_cord;      // destination
    y_cord_t                  y_cord;
    x_cord_t                  src_x_cord;
    y_cord_t                  src_y_cord;
  } manycore_packet_s;

endpackage

`default_nettype wire

/* packet_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module packet_fifo
  import noc_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             v_i,
  input  manycore_packet_s pkt_i,
  output logic             credit_o,
  output logic             v_o,
  output manycore_packet_s pkt_o,
  input  logic             credit_i
);

  localparam int depth_lp          = `LOADER_CREDITS_P;
  localparam int ptr_width_lp      = $clog2(depth_lp);
  localparam int link_cnt_width_lp = $clog2(`LINK_CREDITS_P + 1);

  manycore_packet_s             mem_r [depth_lp];
  logic [ptr_width_lp:0]        wr_ptr_q, rd_ptr_q; // extra bit tells full from empty
  logic [link_cnt_width_lp-1:0] link_cnt_q;
  logic                         empty, pop;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign pop   = !empty && (link_cnt_q != '0);

  assign v_o      = pop;
  assign pkt_o    = mem_r[rd_ptr_q[ptr_width_lp-1:0]];
  assign credit_o = pop; // freed slot goes back to the loader

  //////////////////////////////
  // storage

  // upstream credits keep the writer from overrunning
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      mem_r[wr_ptr_q[ptr_width_lp-1:0]] <= pkt_i;
    end
  end

  //////////////////////////////
  // pointers and link credits

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      link_cnt_q <= link_cnt_width_lp'(`LINK_CREDITS_P);
    end else begin
      if (v_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (pop && !credit_i) begin
        link_cnt_q <= link_cnt_q - 1'b1;
      end else if (!pop && credit_i) begin
        link_cnt_q <= link_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
noc_pkg.sv
loader_pkg.sv
load_image_rom.sv
spmd_loader.sv
packet_fifo.sv
spmd_load_top.sv
spmd_load_assertions.sv
tb_spmd_load_top.sv

/* spmd_load_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module spmd_load_assertions (
  input logic                                     clk_i,
  input logic                                     reset_i,
  input logic                                     v_i,
  input logic                                     v_o,
  input logic                                     credit_i,
  input logic [$clog2(`LOADER_CREDITS_P):0]       wr_ptr_i,
  input logic [$clog2(`LOADER_CREDITS_P):0]       rd_ptr_i,
  input logic [$clog2(`LINK_CREDITS_P + 1)-1:0]   link_cnt_i
);

  logic [$clog2(`LOADER_CREDITS_P):0] occupancy;

  assign occupancy = wr_ptr_i - rd_ptr_i; // wraps cleanly with the extra pointer bit

  //////////////////////////////
  // link credits

  link_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    link_cnt_i <= `LINK_CREDITS_P)
    else $error("link credit count above its initial value");

  // a credit returned while the count is full would overflow it
  no_extra_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    !(credit_i && !v_o && (link_cnt_i == `LINK_CREDITS_P)))
    else $error("link credit returned with the count already full");

  //////////////////////////////
  // queue side and reset

  // the loader writes only while it holds a credit for a free slot
  send_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> (occupancy < `LOADER_CREDITS_P))
    else $error("packet written into a full queue");

  queue_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    occupancy <= `LOADER_CREDITS_P)
    else $error("queue holds more entries than loader credits");

  // outputs are cleared by the first reset edge
  quiet_in_reset: assert property (@(posedge clk_i)
    $past(reset_i) |-> (!v_i && !v_o))
    else $error("valid raised while in reset");

endmodule

bind packet_fifo spmd_load_assertions spmd_load_assertions_inst (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .v_i        (v_i),
  .v_o        (v_o),
  .credit_i   (credit_i),
  .wr_ptr_i   (wr_ptr_q),
  .rd_ptr_i   (rd_ptr_q),
  .link_cnt_i (link_cnt_q)
);

`default_nettype wire

/* spmd_load_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spmd_load_top
  import noc_pkg::*;
  import loader_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  x_cord_t          my_x_i,
  input  y_cord_t          my_y_i,
  output logic             link_v_o,
  output manycore_packet_s link_pkt_o,
  input  logic             link_credit_i,
  output logic             done_o
);

  rom_addr_t        rom_addr;
  image_word_t      rom_data;
  logic             pkt_v;
  manycore_packet_s pkt;
  logic             pkt_credit; // queue pop back to the loader

  load_image_rom load_image_rom_inst (
    .clk_i  (clk_i),
    .addr_i (rom_addr),
    .data_o (rom_data)
  );

  spmd_loader spmd_loader_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .my_x_i     (my_x_i),
    .my_y_i     (my_y_i),
    .rom_addr_o (rom_addr),
    .rom_data_i (rom_data),
    .pkt_v_o    (pkt_v),
    .pkt_o      (pkt),
    .credit_i   (pkt_credit),
    .done_o     (done_o)
  );

  // queue between the loader and the network link
  packet_fifo packet_fifo_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (pkt_v),
    .pkt_i    (pkt),
    .credit_o (pkt_credit),
    .v_o      (link_v_o),
    .pkt_o    (link_pkt_o),
    .credit_i (link_credit_i)
  );

endmodule

`default_nettype wire

/* spmd_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module spmd_loader
  import noc_pkg::*;
  import loader_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  x_cord_t          my_x_i,
  input  y_cord_t          my_y_i,
  output rom_addr_t        rom_addr_o,
  input  image_word_t      rom_data_i,
  output logic             pkt_v_o,
  output manycore_packet_s pkt_o,
  input  logic             credit_i,
  output logic             done_o
);

  localparam int max_lp      = (`DMEM_WORDS_P > `DRAM_WORDS_P) ? `DMEM_WORDS_P : `DRAM_WORDS_P;
  localparam int idx_width_lp = $clog2(max_lp);
  localparam int cnt_width_lp = $clog2(`LOADER_CREDITS_P + 1);

  load_phase_e              phase_q, phase_n, phase_after;
  y_cord_t                  y_q, y_n;
  x_cord_t                  x_q, x_n;
  logic [idx_width_lp-1:0]  idx_q, idx_n, idx_max;
  logic [cnt_width_lp-1:0]  credit_q;
  logic                     active, send;
  logic                     idx_last, x_last, tile_last;
  manycore_packet_s         pkt_n;

  //////////////////////////////
  // sequencing

  assign active    = phase_q inside {e_icache, e_dmem, e_dram, e_unfreeze};
  assign send      = active && (credit_q != '0); // stall while out of credit
  assign idx_last  = (idx_q == idx_max);
  assign x_last    = (x_q == x_cord_t'(`NUM_COLS_P-1));
  assign tile_last = x_last && (y_q == y_cord_t'(`NUM_ROWS_P-1));

  always_comb begin
    case (phase_q)
      e_icache: idx_max = idx_width_lp'(`ICACHE_ENTRIES_P-1);
      e_dmem:   idx_max = idx_width_lp'(`DMEM_WORDS_P-1);
      e_dram:   idx_max = idx_width_lp'(`DRAM_WORDS_P-1);
      default:  idx_max = '0; // one store per tile in unfreeze
    endcase
    case (phase_q)
      e_icache: phase_after = e_dmem;
      e_dmem:   phase_after = e_dram;
      default:  phase_after = e_done;
    endcase
  end

  always_comb begin
    phase_n = phase_q;
    y_n     = y_q;
    x_n     = x_q;
    idx_n   = idx_q;
    case (phase_q)
      e_idle: phase_n = e_icache;
      e_icache, e_dmem, e_unfreeze: begin
        if (send) begin
          if (!idx_last) begin
            idx_n = idx_q + 1'b1;
          end else begin
            idx_n = '0;
            if (tile_last) begin // y then x order
              x_n     = '0;
              y_n     = '0;
              phase_n = phase_after;
            end else if (x_last) begin
              x_n = '0;
              y_n = y_q + 1'b1;
            end else begin
              x_n = x_q + 1'b1;
            end
          end
        end
      end
      e_dram: begin
        if (send) begin
          if (!idx_last) begin
            idx_n = idx_q + 1'b1;
          end else begin
            idx_n   = '0;
            phase_n = e_unfreeze;
          end
        end
      end
      default: phase_n = phase_q; // done holds
    endcase
  end

  // rom is addressed with the next word so its data is ready when the packet is built
  always_comb begin
    case (phase_n)
      e_dmem:  rom_addr_o = rom_addr_t'(idx_n);
      e_dram:  rom_addr_o = rom_addr_t'(`DMEM_WORDS_P) + rom_addr_t'(idx_n);
      default: rom_addr_o = '0;
    endcase
  end

  //////////////////////////////
  // packet assembly

  always_comb begin
    pkt_n            = '0;
    pkt_n.op         = e_remote_store;
    pkt_n.mask       = 4'hf;
    pkt_n.x_cord     = x_q;
    pkt_n.y_cord     = y_q;
    pkt_n.src_x_cord = my_x_i;
    pkt_n.src_y_cord = my_y_i;
    case (phase_q)
      e_icache: pkt_n.addr.epa.offset = (`EPA_ADDR_WIDTH_P-1)'(idx_q); // tag entry, data 0
      e_dmem: begin
        pkt_n.addr.epa.offset = (`EPA_ADDR_WIDTH_P-1)'(idx_q);
        pkt_n.data            = rom_data_i;
      end
      e_dram: begin
        pkt_n.addr   = `ADDR_WIDTH_P'(idx_q);
        pkt_n.data   = rom_data_i;
        // controller column comes from the address, row is the one below the array
        pkt_n.x_cord = pkt_n.addr.dram.x_cord;
        pkt_n.y_cord = '1;
      end
      e_unfreeze: pkt_n.addr.epa.config_bit = 1'b1;
      default: pkt_n.data = '0;
    endcase
  end

  //////////////////////////////
  // state and outputs

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_q  <= e_idle;
      y_q      <= '0;
      x_q      <= '0;
      idx_q    <= '0;
      credit_q <= cnt_width_lp'(`LOADER_CREDITS_P);
      pkt_v_o  <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      phase_q <= phase_n;
      y_q     <= y_n;
      x_q     <= x_n;
      idx_q   <= idx_n;
      if (send && !credit_i) begin
        credit_q <= credit_q - 1'b1;
      end else if (!send && credit_i) begin
        credit_q <= credit_q + 1'b1;
      end
      pkt_v_o <= send;
      done_o  <= (phase_q == e_done); // one cycle after the last send
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      pkt_o <= pkt_n;
    end
  end

endmodule

`default_nettype wire

/* tb_spmd_load_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module tb_spmd_load_top
  import noc_pkg::*;
  import loader_pkg::*;
();

  localparam int tiles_lp     = `NUM_ROWS_P * `NUM_COLS_P;
  localparam int icache_n_lp  = tiles_lp * `ICACHE_ENTRIES_P;
  localparam int dmem_n_lp    = tiles_lp * `DMEM_WORDS_P;
  localparam int dram_n_lp    = `DRAM_WORDS_P;
  localparam int total_lp     = icache_n_lp + dmem_n_lp + dram_n_lp + tiles_lp;
  localparam int period_lp    = 40;
  localparam int max_delay_lp = 8;   // credit return delay in cycles
  localparam int max_hold_lp  = 104; // longest credit stall
  localparam int run_limit_lp = total_lp * (max_delay_lp + max_hold_lp) + 200;
  localparam x_cord_t src_x_lp = 2'd1;
  localparam y_cord_t src_y_lp = 2'd0;

  logic             clk, reset, link_v, link_credit, done;
  x_cord_t          my_x;
  y_cord_t          my_y;
  manycore_packet_s link_pkt;

  image_word_t image_mem [`DMEM_WORDS_P + `DRAM_WORDS_P];
  logic [31:0] rng_state;
  int          err_count, tests_run, tests_failed;
  int          rx_count, cycle_count, hold_cnt, phase_base, run;
  logic        long_holds;
  int          credit_due_q [$]; // cycle at which each owed credit goes back

  spmd_load_top spmd_load_top_inst (
    .clk_i         (clk),
    .reset_i       (reset),
    .my_x_i        (my_x),
    .my_y_i        (my_y),
    .link_v_o      (link_v),
    .link_pkt_o    (link_pkt),
    .link_credit_i (link_credit),
    .done_o        (done)
  );

  initial begin
    clk = 1'b0;
    forever #(period_lp / 2) clk = ~clk;
  end

  //////////////////////////////
  // helpers

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic string phase_name(input int n);
    if (n < icache_n_lp) begin
      return "icache phase";
    end else if (n < icache_n_lp + dmem_n_lp) begin
      return "dmem phase";
    end else if (n < icache_n_lp + dmem_n_lp + dram_n_lp) begin
      return "dram phase";
    end
    return "unfreeze phase";
  endfunction

  // packet n of the stream, tiles walk y then x
  function automatic manycore_packet_s expected_packet(input int n);
    manycore_packet_s p;
    packet_addr_u     a;
    int               tile, k;
    p            = '0;
    p.op         = e_remote_store;
    p.mask       = 4'hf;
    p.src_x_cord = src_x_lp;
    p.src_y_cord = src_y_lp;
    tile         = 0;
    if (n < icache_n_lp) begin
      tile   = n / `ICACHE_ENTRIES_P;
      p.addr = `ADDR_WIDTH_P'(n % `ICACHE_ENTRIES_P); // tag entry cleared with data 0
    end else if (n < icache_n_lp + dmem_n_lp) begin
      k      = n - icache_n_lp;
      tile   = k / `DMEM_WORDS_P;
      p.data = image_mem[k % `DMEM_WORDS_P];
      p.addr = `ADDR_WIDTH_P'(k % `DMEM_WORDS_P);
    end else if (n < icache_n_lp + dmem_n_lp + dram_n_lp) begin
      k        = n - icache_n_lp - dmem_n_lp;
      a        = `ADDR_WIDTH_P'(k);
      p.data   = image_mem[`DMEM_WORDS_P + k];
      p.addr   = a;
      p.x_cord = a.dram.x_cord; // controller column from the address
      p.y_cord = '1;            // row below the array
      return p;
    end else begin
      tile   = n - icache_n_lp - dmem_n_lp - dram_n_lp;
      p.addr = `ADDR_WIDTH_P'(1) << (`EPA_ADDR_WIDTH_P - 1); // config word
    end
    p.x_cord = x_cord_t'(tile % `NUM_COLS_P);
    p.y_cord = y_cord_t'(tile / `NUM_COLS_P);
    return p;
  endfunction

  task automatic compare_packet(input string name, input manycore_packet_s exp,
                                input manycore_packet_s act);
    if (act !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("run %0d %-16s %s, %0d errors", run, name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  //////////////////////////////
  // network model

  always begin
    logic        in_reset;
    logic [31:0] r;
    @(posedge clk);
    in_reset = reset;
    #2;
    cycle_count++;
    link_credit = 1'b0;
    r = next_rand();
    if (in_reset) begin
      credit_due_q.delete(); // counters in the dut start full again
      hold_cnt = 0;
    end else if (hold_cnt > 0) begin
      hold_cnt--;
    end else if (long_holds ? (r[3:0] == 4'h0) : (r[4:0] == 5'h0)) begin
      hold_cnt = long_holds ? 40 + int'(r[10:5]) : 4 + int'(r[7:5]);
    end else if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle_count) begin
      link_credit = 1'b1;
      void'(credit_due_q.pop_front());
    end
  end

  // compares each packet as it leaves the link
  always @(negedge clk) begin
    if (!reset && link_v) begin
      if (rx_count >= total_lp) begin
        $display("run %0d: packet arrived after the end of the stream", run);
        err_count++;
      end else begin
        if (rx_count == 0 || phase_name(rx_count) != phase_name(rx_count - 1)) begin
          phase_base = err_count;
        end
        if (rx_count == 0) begin
          compare_bit("done_o", 1'b0, done);
        end
        compare_packet($sformatf("link_pkt_o[%0d]", rx_count), expected_packet(rx_count),
                       link_pkt);
        if (rx_count == total_lp - 1 || phase_name(rx_count) != phase_name(rx_count + 1)) begin
          report_test(phase_name(rx_count), err_count - phase_base);
        end
      end
      credit_due_q.push_back(cycle_count + 1 + int'(next_rand() % max_delay_lp));
      rx_count++;
    end
  end

  //////////////////////////////
  // test sequence

  initial begin
    int cycles;
    int base;
    reset        = 1'b1;
    my_x         = src_x_lp;
    my_y         = src_y_lp;
    link_credit  = 1'b0;
    rng_state    = 32'h2bb01b3f;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    rx_count     = 0;
    cycle_count  = 0;
    hold_cnt     = 0;
    phase_base   = 0;
    long_holds   = 1'b0;
    $readmemh("image.hex", image_mem);
    for (run = 1; run <= 2; run++) begin
      base       = err_count;
      long_holds = (run == 2); // second run stalls the link for long stretches
      if (run > 1) begin
        @(posedge clk);
        #2;
        reset = 1'b1;
      end
      rx_count = 0;
      repeat (3) begin
        @(posedge clk);
        @(negedge clk);
        compare_bit("link_v_o", 1'b0, link_v);
        compare_bit("done_o", 1'b0, done);
      end
      @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      compare_bit("link_v_o", 1'b0, link_v);
      compare_bit("done_o", 1'b0, done);
      report_test("reset", err_count - base);

      base   = err_count;
      cycles = 0;
      while (!(done && rx_count >= total_lp) && cycles < run_limit_lp) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (cycles >= run_limit_lp) begin
        $display("run %0d: stream stalled after %0d of %0d packets", run, rx_count, total_lp);
        err_count++;
      end
      repeat (20) begin // link must stay idle with done held
        @(negedge clk);
        compare_bit("done_o", 1'b1, done);
      end
      if (rx_count != total_lp) begin
        $display("run %0d: %0d packets received instead of %0d", run, rx_count, total_lp);
        err_count++;
      end
      report_test("end of stream", err_count - base);
    end
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // both runs at their worst stall, plus reset and idle time
  initial begin
    #((2 * run_limit_lp + 400) * period_lp);
    $display("watchdog expired in run %0d with %0d packets received", run, rx_count);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
